/* Bender.yml */
package:
  name: soc_fabric

sources:
  - include_dirs:
      - include
    files:
      - design/soc_pkg.sv
      - design/bus_router.sv
      - design/boot_rom.sv
      - design/scratch_ram.sv
      - design/core_timer.sv
      - design/soc_fabric.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/bus_checker.sv
      - verification/soc_fabric_tb.sv

/* design/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  `include "boot_rom_image.svh"

  logic [31:0]                rom_array [rom_words];
  logic [rom_index_width-1:0] index;
  logic [31:0]                rdata_q;
  logic                       ready_q;

  initial begin
    for (int i = 0; i < rom_words; i++) begin
      rom_array[i] = boot_rom_word(i);
    end
  end

  assign index = req.addr[rom_index_width+1:2]; // Byte offset to word index.

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.valid && !ready_q;
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata_q <= rom_array[index];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.error = 1'b0;
  assign rsp.rdata = rdata_q;

  // Writes to the ROM region must have been turned into errors upstream.
  assert property (@(posedge clock) disable iff (reset) req.valid |-> req.wstrb == 4'b0000)
    else $error("Boot ROM enabled for a write.");

endmodule

/* design/bus_router.sv */
`timescale 1ns/1ps

module bus_router
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t host_req,
  output mem_rsp_t host_rsp,
  output mem_req_t rom_req,
  output mem_req_t ram_req,
  output mem_req_t timer_req,
  input  mem_rsp_t rom_rsp,
  input  mem_rsp_t ram_rsp,
  input  mem_rsp_t timer_rsp
);

  logic        in_rom;
  logic        in_ram;
  logic        in_timer;
  logic        is_write;
  logic        rom_en;
  logic        ram_en;
  logic        timer_en;
  logic        err_en;
  logic        err_ready;
  logic [31:0] base_addr;
  logic [31:0] offset;

  assign in_rom = host_req.addr >= rom_base_addr && host_req.addr < rom_top_addr;
  assign in_ram = host_req.addr >= ram_base_addr && host_req.addr < ram_top_addr;
  assign in_timer = host_req.addr >= timer_base_addr && host_req.addr < timer_top_addr;
  assign is_write = host_req.wstrb != 4'b0000;

  always_comb begin
    base_addr = '0;
    rom_en = 1'b0;
    ram_en = 1'b0;
    timer_en = 1'b0;
    if (in_rom) begin
      base_addr = rom_base_addr;
      rom_en = host_req.valid && !is_write; // The ROM takes no writes.
    end else if (in_ram) begin
      base_addr = ram_base_addr;
      ram_en = host_req.valid;
    end else if (in_timer) begin
      base_addr = timer_base_addr;
      timer_en = host_req.valid && !host_req.instr;
    end
  end

  // Anything valid that no target accepts is answered here.
  assign err_en = host_req.valid && !(rom_en || ram_en || timer_en);
  assign offset = host_req.addr - base_addr;

  always_comb begin
    rom_req = host_req;
    rom_req.addr = offset;
    rom_req.valid = rom_en;
    ram_req = host_req;
    ram_req.addr = offset;
    ram_req.valid = ram_en;
    timer_req = host_req;
    timer_req.addr = offset;
    timer_req.valid = timer_en;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= err_en && !err_ready; // Valid is still held in the ready cycle.
    end
  end

  always_comb begin
    if (rom_rsp.ready) begin
      host_rsp = rom_rsp;
    end else if (ram_rsp.ready) begin
      host_rsp = ram_rsp;
    end else if (timer_rsp.ready) begin
      host_rsp = timer_rsp;
    end else if (err_ready) begin
      host_rsp.ready = 1'b1;
      host_rsp.error = 1'b1;
      host_rsp.rdata = '0;
    end else begin
      host_rsp = '0;
    end
  end

  // Only one access is in flight, so at most one source may answer.
  assert property (@(posedge clock) disable iff (reset)
    $onehot0({rom_rsp.ready, ram_rsp.ready, timer_rsp.ready, err_ready}))
    else $error("More than one response source is ready.");

endmodule

/* design/core_timer.sv */
`timescale 1ns/1ps

module core_timer
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t req,
  output mem_rsp_t rsp,
  output logic     msip,
  output logic     mtip
);

  logic [63:0] mtime_q;
  logic [63:0] mtime_next;
  logic [63:0] cmp_q;
  logic        msip_q;
  logic        mtip_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] read_word;
  logic [15:0] offset;
  logic        accept;
  logic        write;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strobe);
    logic [31:0] result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strobe[lane]) begin
        result[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  assign offset = req.addr[15:0];
  assign accept = req.valid && !ready_q;
  assign write = accept && req.wstrb != 4'b0000;

  always_comb begin
    mtime_next = mtime_q + 64'd1;
    if (write && offset == timer_time_lo_offset) begin
      mtime_next[31:0] = merge_bytes(mtime_q[31:0], req.wdata, req.wstrb);
    end else if (write && offset == timer_time_hi_offset) begin
      mtime_next[63:32] = merge_bytes(mtime_q[63:32], req.wdata, req.wstrb);
    end
  end

  always_comb begin
    case (offset)
      timer_msip_offset:    read_word = {31'b0, msip_q};
      timer_cmp_lo_offset:  read_word = cmp_q[31:0];
      timer_cmp_hi_offset:  read_word = cmp_q[63:32];
      timer_time_lo_offset: read_word = mtime_q[31:0];
      timer_time_hi_offset: read_word = mtime_q[63:32];
      default:              read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
      cmp_q <= '1; // No timer interrupt until software sets a compare value.
      msip_q <= 1'b0;
      mtip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      mtime_q <= mtime_next;
      mtip_q <= mtime_q >= cmp_q;
      ready_q <= accept;
      if (write && offset == timer_msip_offset && req.wstrb[0]) begin
        msip_q <= req.wdata[0];
      end
      if (write && offset == timer_cmp_lo_offset) begin
        cmp_q[31:0] <= merge_bytes(cmp_q[31:0], req.wdata, req.wstrb);
      end
      if (write && offset == timer_cmp_hi_offset) begin
        cmp_q[63:32] <= merge_bytes(cmp_q[63:32], req.wdata, req.wstrb);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= write ? '0 : read_word;
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.error = 1'b0;
  assign rsp.rdata = rdata_q;
  assign msip = msip_q;
  assign mtip = mtip_q;

  // Fetches from this region are answered with an error by the router.
  assert property (@(posedge clock) disable iff (reset) req.valid |-> !req.instr)
    else $error("Instruction fetch reached the timer.");

endmodule

/* design/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  logic [31:0]                mem [ram_words];
  logic [ram_index_width-1:0] index;
  logic                       accept;
  logic                       ready_q;
  logic [31:0]                rdata_q;

  assign index = req.addr[ram_index_width+1:2];
  assign accept = req.valid && !ready_q; // One acceptance per request.

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (req.wstrb[lane]) begin
          mem[index][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
        end
      end
      if (req.wstrb == 4'b0000) begin
        rdata_q <= mem[index];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.error = 1'b0;
  assign rsp.rdata = rdata_q;

  // The router rebases the address, so only region offsets should arrive.
  assert property (@(posedge clock) disable iff (reset)
    req.valid |-> req.addr < (ram_top_addr - ram_base_addr))
    else $error("Scratch RAM offset 0x%08h out of range.", req.addr);

endmodule

/* design/soc_fabric.sv */
`timescale 1ns/1ps

module soc_fabric
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t host_req,
  output mem_rsp_t host_rsp,
  output logic     msip,
  output logic     mtip
);

  mem_req_t rom_req;
  mem_req_t ram_req;
  mem_req_t timer_req;
  mem_rsp_t rom_rsp;
  mem_rsp_t ram_rsp;
  mem_rsp_t timer_rsp;

  bus_router router_inst (
    .clock     (clock),
    .reset     (reset),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .rom_req   (rom_req),
    .ram_req   (ram_req),
    .timer_req (timer_req),
    .rom_rsp   (rom_rsp),
    .ram_rsp   (ram_rsp),
    .timer_rsp (timer_rsp)
  );

  boot_rom rom_inst (
    .clock (clock),
    .reset (reset),
    .req   (rom_req),
    .rsp   (rom_rsp)
  );

  scratch_ram ram_inst (
    .clock (clock),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  core_timer timer_inst (
    .clock (clock),
    .reset (reset),
    .req   (timer_req),
    .rsp   (timer_rsp),
    .msip  (msip),
    .mtip  (mtip)
  );

endmodule

/* design/soc_pkg.sv */
package soc_pkg;

  localparam logic [31:0] rom_base_addr = 32'h0000_0000;
  localparam logic [31:0] rom_top_addr = 32'h0000_0400;
  localparam logic [31:0] ram_base_addr = 32'h0001_0000;
  localparam logic [31:0] ram_top_addr = 32'h0001_1000;
  localparam logic [31:0] timer_base_addr = 32'h0200_0000;
  localparam logic [31:0] timer_top_addr = 32'h0201_0000;

  localparam logic [15:0] timer_msip_offset = 16'h0000;
  localparam logic [15:0] timer_cmp_lo_offset = 16'h4000;
  localparam logic [15:0] timer_cmp_hi_offset = 16'h4004;
  localparam logic [15:0] timer_time_lo_offset = 16'hBFF8;
  localparam logic [15:0] timer_time_hi_offset = 16'hBFFC;

  localparam int rom_words = 256;
  localparam int ram_words = 1024;
  localparam int rom_index_width = $clog2(rom_words);
  localparam int ram_index_width = $clog2(ram_words);

  // Request from the requester, or from the router to one target.
  typedef struct packed {
    logic        valid;
    logic        instr; // Set for an instruction fetch.
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb; // All zero means a read.
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

/* include/boot_rom_image.svh */
// Contents of the boot ROM, one word per word index.
// The ROM fills itself from this rule, and the checker predicts read data from it.

function automatic logic [31:0] boot_rom_word(input int unsigned index);
  logic [31:0] x;
  x = index * 32'h9E37_79B1 + 32'h1357_9BDF;
  x = x ^ (x >> 15);
  x = x * 32'h85EB_CA6B;
  x = x ^ (x >> 13);
  x = x * 32'hC2B2_AE35;
  x = x ^ (x >> 16);
  return x;
endfunction

/* soc_fabric.f */
+incdir+include
design/soc_pkg.sv
design/bus_router.sv
design/boot_rom.sv
design/scratch_ram.sv
design/core_timer.sv
design/soc_fabric.sv
verification/bus_checker.sv
verification/soc_fabric_tb.sv

/* verification/bus_checker.sv */
`timescale 1ns/1ps

module bus_checker
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t host_req,
  input  mem_rsp_t host_rsp,
  input  logic     msip,
  input  logic     mtip,
  output int       error_count
);

  `include "boot_rom_image.svh"

  logic [31:0] shadow [ram_words];
  logic [3:0]  known [ram_words]; // Byte lanes of each word that have been written.
  logic        msip_model;
  logic [63:0] cmp_model;
  logic        pending;
  mem_req_t    pend_req;
  logic [31:0] exp_rdata;
  logic [31:0] exp_mask;
  logic        exp_error;
  logic        time_read;
  logic        cmp_written;
  logic        have_time;
  logic [31:0] last_time;
  logic        mtip_expect;
  int          mtip_wait;

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strobe);
    logic [31:0] result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strobe[lane]) begin
        result[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  // Works out the response for a request and applies its effect on the model.
  task automatic predict(input mem_req_t req);
    logic [31:0] rebased;
    logic [15:0] offset;
    logic        write;
    write = req.wstrb != 4'b0000;
    exp_rdata = '0;
    exp_mask = '1;
    exp_error = 1'b0;
    time_read = 1'b0;
    cmp_written = 1'b0;
    if (req.addr >= rom_base_addr && req.addr < rom_top_addr && !write) begin
      exp_rdata = boot_rom_word((req.addr - rom_base_addr) >> 2);
    end else if (req.addr >= ram_base_addr && req.addr < ram_top_addr) begin
      rebased = (req.addr - ram_base_addr) >> 2;
      if (write) begin
        shadow[rebased] = merge_lanes(shadow[rebased], req.wdata, req.wstrb);
        known[rebased] = known[rebased] | req.wstrb;
      end else begin
        exp_rdata = shadow[rebased];
        exp_mask = {{8{known[rebased][3]}}, {8{known[rebased][2]}},
                    {8{known[rebased][1]}}, {8{known[rebased][0]}}};
      end
    end else if (req.addr >= timer_base_addr && req.addr < timer_top_addr && !req.instr) begin
      rebased = req.addr - timer_base_addr;
      offset = rebased[15:0];
      if (write) begin
        if (offset == timer_msip_offset && req.wstrb[0]) begin
          msip_model = req.wdata[0];
        end
        if (offset == timer_cmp_lo_offset) begin
          cmp_model[31:0] = merge_lanes(cmp_model[31:0], req.wdata, req.wstrb);
          cmp_written = 1'b1;
        end
        if (offset == timer_cmp_hi_offset) begin
          cmp_model[63:32] = merge_lanes(cmp_model[63:32], req.wdata, req.wstrb);
          cmp_written = 1'b1;
        end
      end else if (offset == timer_msip_offset) begin
        exp_rdata = {31'b0, msip_model};
      end else if (offset == timer_cmp_lo_offset) begin
        exp_rdata = cmp_model[31:0];
      end else if (offset == timer_cmp_hi_offset) begin
        exp_rdata = cmp_model[63:32];
      end else if (offset == timer_time_lo_offset) begin
        time_read = 1'b1;
      end else if (offset == timer_time_hi_offset) begin
        exp_mask = '0; // The upper half depends on the exact cycle count.
      end
    end else begin
      exp_error = 1'b1; // Unmapped, a ROM write, or a fetch from the timer.
    end
  endtask

  initial begin
    error_count = 0;
    for (int i = 0; i < ram_words; i++) begin
      known[i] = 4'b0000;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      pending = 1'b0;
      msip_model = 1'b0;
      cmp_model = '1;
      have_time = 1'b0;
      mtip_wait = 0;
    end else begin
      if (msip !== msip_model) begin
        $display("MISMATCH msip: expected 0x%0h, actual 0x%0h", msip_model, msip);
        error_count++;
      end
      if (mtip_wait > 0) begin
        if (mtip === mtip_expect) begin
          mtip_wait = 0;
        end else begin
          mtip_wait--;
          if (mtip_wait == 0) begin
            $display("mtip did not follow the compare write within two cycles.");
            error_count++;
          end
        end
      end
      if (pending) begin
        pending = 1'b0; // The requester still holds valid in this cycle.
        if (host_rsp.ready !== 1'b1) begin
          $display("No ready one cycle after the request to 0x%08h.", pend_req.addr);
          error_count++;
        end else begin
          if (host_rsp.error !== exp_error) begin
            $display("MISMATCH host_rsp.error at 0x%08h: expected 0x%0h, actual 0x%0h",
                     pend_req.addr, exp_error, host_rsp.error);
            error_count++;
          end
          if (time_read) begin
            if (have_time && (host_rsp.rdata > last_time) !== 1'b1) begin
              $display("Time low half did not increase: 0x%08h after 0x%08h.",
                       host_rsp.rdata, last_time);
              error_count++;
            end
            have_time = 1'b1;
            last_time = host_rsp.rdata;
          end else if ((host_rsp.rdata & exp_mask) !== (exp_rdata & exp_mask)) begin
            $display("MISMATCH host_rsp.rdata at 0x%08h: expected 0x%08h, actual 0x%08h",
                     pend_req.addr, exp_rdata & exp_mask, host_rsp.rdata & exp_mask);
            error_count++;
          end
          if (cmp_written && (cmp_model == '0 || cmp_model == '1)) begin
            mtip_expect = cmp_model == '0;
            mtip_wait = 2;
          end
        end
      end else if (host_rsp.ready === 1'b1) begin
        $display("Ready seen with no request pending.");
        error_count++;
      end else if (host_req.valid === 1'b1) begin
        pending = 1'b1;
        pend_req = host_req;
        predict(host_req);
      end
    end
  end

endmodule

/* verification/soc_fabric_tb.sv */
`timescale 1ns/1ps

module soc_fabric_tb
  import soc_pkg::*;
();

  localparam int rom_reads = 200;
  localparam int ram_accesses = 300;
  localparam int error_accesses = 7;
  localparam int msip_accesses = 4;
  localparam int cmp_accesses = 11;
  localparam int time_reads = 8;
  localparam int planned_accesses = rom_reads + ram_accesses + error_accesses
                                    + msip_accesses + cmp_accesses + time_reads;
  localparam int cycle_limit = 3 * planned_accesses * 3 + 100;
  localparam logic [31:0] msip_addr = timer_base_addr + timer_msip_offset;
  localparam logic [31:0] cmp_lo_addr = timer_base_addr + timer_cmp_lo_offset;
  localparam logic [31:0] cmp_hi_addr = timer_base_addr + timer_cmp_hi_offset;
  localparam logic [31:0] time_lo_addr = timer_base_addr + timer_time_lo_offset;

  logic        clock;
  logic        reset;
  mem_req_t    host_req;
  mem_rsp_t    host_rsp;
  logic        msip;
  logic        mtip;
  int          error_count;
  int          cycles = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] rng_state = 32'd52302;

  soc_fabric UUT (
    .clock    (clock),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .msip     (msip),
    .mtip     (mtip)
  );

  bus_checker checker_inst (
    .clock       (clock),
    .reset       (reset),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .msip        (msip),
    .mtip        (mtip),
    .error_count (error_count)
  );

  function automatic logic [31:0] random_word();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the bus stopped answering.", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Starts 1 ns after an edge and returns 1 ns after the ready edge.
  task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] wstrb, input logic instr);
    host_req.valid = 1'b1;
    host_req.instr = instr;
    host_req.addr = addr;
    host_req.wdata = wdata;
    host_req.wstrb = wstrb;
    @(posedge clock);
    while (host_rsp.ready !== 1'b1) @(posedge clock);
    #1;
    host_req.valid = 1'b0;
  endtask

  task automatic idle(input int count);
    repeat (count) @(posedge clock);
    #1;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("Test %s: PASS", name);
      tests_passed++;
    end else begin
      $display("Test %s: FAIL", name);
      tests_failed++;
    end
  endtask

  initial begin
    int          errors_before;
    logic [31:0] r;
    logic [3:0]  strobe;
    host_req = '0;
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    errors_before = error_count;
    for (int i = 0; i < rom_reads; i++) begin
      r = random_word();
      access(rom_base_addr + {22'b0, r[9:2], 2'b00}, '0, 4'b0000, r[16]);
    end
    report_test("boot ROM reads", errors_before);

    errors_before = error_count;
    for (int i = 0; i < ram_accesses; i++) begin
      r = random_word();
      strobe = r[5] ? r[9:6] : 4'b0000;
      access(ram_base_addr + {20'b0, r[4:0], 7'b0}, random_word(), strobe, 1'b0);
    end
    report_test("scratch RAM access", errors_before);

    errors_before = error_count;
    access(rom_top_addr, '0, 4'b0000, 1'b0); // Gap between ROM and RAM.
    access(ram_top_addr, random_word(), 4'b1111, 1'b0);
    access(32'h8000_0000, random_word(), 4'b0011, 1'b0);
    access(rom_base_addr + 32'h10, 32'hdead_beef, 4'b1111, 1'b0);
    access(msip_addr, 32'h1, 4'b1111, 1'b1);
    access(time_lo_addr, '0, 4'b0000, 1'b1);
    access(ram_base_addr, '0, 4'b0000, 1'b0);
    report_test("error responses", errors_before);

    errors_before = error_count;
    access(msip_addr, 32'h1, 4'b0001, 1'b0);
    access(msip_addr, '0, 4'b0000, 1'b0);
    access(msip_addr, 32'hffff_fffe, 4'b1111, 1'b0);
    access(msip_addr, '0, 4'b0000, 1'b0);
    report_test("software interrupt", errors_before);

    errors_before = error_count;
    access(cmp_lo_addr, '0, 4'b1111, 1'b0);
    access(cmp_hi_addr, '0, 4'b1111, 1'b0);
    idle(3); // The checker expects mtip within two cycles.
    access(cmp_lo_addr, '0, 4'b0000, 1'b0);
    access(cmp_hi_addr, '0, 4'b0000, 1'b0);
    access(cmp_lo_addr, '1, 4'b1111, 1'b0);
    access(cmp_hi_addr, '1, 4'b1111, 1'b0);
    idle(3);
    access(cmp_lo_addr, 32'h1234_5678, 4'b0101, 1'b0);
    access(cmp_lo_addr, '0, 4'b0000, 1'b0);
    access(cmp_hi_addr, '0, 4'b0000, 1'b0);
    access(cmp_lo_addr, '1, 4'b1111, 1'b0);
    access(cmp_lo_addr, '0, 4'b0000, 1'b0);
    report_test("timer interrupt", errors_before);

    errors_before = error_count;
    for (int i = 0; i < time_reads; i++) begin
      access(time_lo_addr, '0, 4'b0000, 1'b0);
    end
    report_test("time counter", errors_before);

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
